/* axi_rd_mem.f */
rtl/axi_rd_pkg.sv
rtl/sync_fifo_zl.sv
rtl/rd_latency_timer.sv
rtl/rd_mem.sv
rtl/axil_rd_ctrl.sv
rtl/axi_axil_reflect_rd.sv
rtl/axi_rd_mem_top.sv
verif/tb_axi_rd_mem.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

TOP=tb_axi_rd_mem
LOG=sim.log

verilator --binary --timing --assert --top-module "$TOP" -f axi_rd_mem.f -o "$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q -F '** FAIL **' "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation finished without failure"
exit 0

/* verif/tb_axi_rd_mem.sv */
module tb_axi_rd_mem;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int ADDR_WIDTH              = 8;
  localparam int DATA_WIDTH              = 32;
  localparam int ID_WIDTH                = 4;
  localparam int OUTSTANDING_READS_WIDTH = 2;
  localparam int MEM_WORDS               = 48;
  localparam int INDEX_W                 = ADDR_WIDTH - 2;
  localparam int INDEX_SPAN              = 1 << INDEX_W;
  localparam int BEAT_W                  = ID_WIDTH + DATA_WIDTH + 2;
  localparam int MAX_CYCLES              = 2000;

  logic                              clk;
  logic                              i_rst_n;
  logic                              i_arvalid;
  logic [ID_WIDTH-1:0]               i_arid;
  logic [ADDR_WIDTH-1:0]             i_araddr;
  logic [axi_rd_pkg::AXI_LEN_W-1:0]   i_arlen;
  logic [axi_rd_pkg::AXI_SIZE_W-1:0]  i_arsize;
  logic [axi_rd_pkg::AXI_BURST_W-1:0] i_arburst;
  logic                              o_arready;
  logic                              o_rvalid;
  logic [ID_WIDTH-1:0]               o_rid;
  logic [DATA_WIDTH-1:0]             o_rdata;
  logic [axi_rd_pkg::AXI_RESP_W-1:0]  o_rresp;
  logic                              o_rlast;
  logic                              i_rready;
  logic                              i_wr_en;
  logic [INDEX_W-1:0]                i_wr_addr;
  logic [DATA_WIDTH-1:0]             i_wr_data;

  // Memory mirror and expected beats in request order
  logic [DATA_WIDTH-1:0] mirror [MEM_WORDS];
  logic [BEAT_W-1:0]     exp_q [$];
  logic [31:0]           rng_state = 32'h5b9850f0;
  int                    errors = 0;
  int                    cycles = 0;
  int                    ar_count = 0;
  int                    beat_count = 0;
  bit                    hold_pending;
  logic [BEAT_W-1:0]     held_beat;

  axi_rd_mem_top #(
    .ADDR_WIDTH             (ADDR_WIDTH),
    .DATA_WIDTH             (DATA_WIDTH),
    .ID_WIDTH               (ID_WIDTH),
    .OUTSTANDING_READS_WIDTH(OUTSTANDING_READS_WIDTH),
    .MEM_WORDS              (MEM_WORDS)
  ) DUT (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .i_arvalid(i_arvalid),
    .i_arid   (i_arid),
    .i_araddr (i_araddr),
    .i_arlen  (i_arlen),
    .i_arsize (i_arsize),
    .i_arburst(i_arburst),
    .o_arready(o_arready),
    .o_rvalid (o_rvalid),
    .o_rid    (o_rid),
    .o_rdata  (o_rdata),
    .o_rresp  (o_rresp),
    .o_rlast  (o_rlast),
    .i_rready (i_rready),
    .i_wr_en  (i_wr_en),
    .i_wr_addr(i_wr_addr),
    .i_wr_data(i_wr_data)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("errors: %0d", errors);
      $display("** FAIL **");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [ADDR_WIDTH-1:0] word_addr(input int index);
    logic [INDEX_W-1:0] w;
    w = INDEX_W'(index);
    return {w, 2'b00};
  endfunction

  // In range words give their preload with OKAY and the rest zero with SLVERR
  function automatic logic [BEAT_W-1:0] expected_beat(input logic [ID_WIDTH-1:0] id,
                                                      input logic [ADDR_WIDTH-1:0] addr);
    int idx;
    idx = int'(addr[ADDR_WIDTH-1:2]);
    if (idx < MEM_WORDS) begin
      return {id, mirror[idx], axi_rd_pkg::RESP_OKAY};
    end
    return {id, {DATA_WIDTH{1'b0}}, axi_rd_pkg::RESP_SLVERR};
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] want,
                                 input logic [63:0] got);
    errors++;
    $display("error at %0d ns: %s expected %0h got %0h", $time, name, want, got);
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("failure at %0d ns: %s", $time, what);
  endtask

  // Samples one ns after the falling edge once all inputs have settled
  always @(negedge clk) begin : r_monitor
    logic [BEAT_W-1:0] want;
    #1;
    if (i_rst_n) begin
      if (hold_pending) begin
        if (!o_rvalid) begin
          report_failure("o_rvalid dropped before the beat was accepted");
        end else if ({o_rid, o_rdata, o_rresp} !== held_beat) begin
          report_mismatch("held R payload", 64'(held_beat), 64'({o_rid, o_rdata, o_rresp}));
        end
      end
      if (o_rvalid && i_rready) begin
        if (exp_q.size() == 0) begin
          report_failure("R beat arrived with no outstanding read");
        end else begin
          want = exp_q.pop_front();
          beat_count++;
          if (o_rid !== want[DATA_WIDTH+2 +: ID_WIDTH]) begin
            report_mismatch("o_rid", 64'(want[DATA_WIDTH+2 +: ID_WIDTH]), 64'(o_rid));
          end
          if (o_rdata !== want[2 +: DATA_WIDTH]) begin
            report_mismatch("o_rdata", 64'(want[2 +: DATA_WIDTH]), 64'(o_rdata));
          end
          if (o_rresp !== want[1:0]) begin
            report_mismatch("o_rresp", 64'(want[1:0]), 64'(o_rresp));
          end
          if (o_rlast !== 1'b1) begin
            report_mismatch("o_rlast", 64'(1), 64'(o_rlast));
          end
        end
      end
      if (i_arvalid && o_arready) begin
        exp_q.push_back(expected_beat(i_arid, i_araddr));
        ar_count++;
      end
      hold_pending = o_rvalid && !i_rready;
      held_beat    = {o_rid, o_rdata, o_rresp};
    end
  end

  task automatic drive_ar(input logic [ID_WIDTH-1:0] id, input logic [ADDR_WIDTH-1:0] addr);
    i_arvalid = 1'b1;
    i_arid    = id;
    i_araddr  = addr;
  endtask

  task automatic drive_random_read(input bit in_range);
    logic [31:0] r;
    int          idx;
    r = next_rand();
    if (in_range) begin
      idx = int'(r[31:8] % MEM_WORDS);
    end else begin
      idx = MEM_WORDS + int'(r[31:8] % (INDEX_SPAN - MEM_WORDS));
    end
    drive_ar(r[ID_WIDTH-1:0], word_addr(idx));
  endtask

  // Returns once the address transfers on the coming rising edge
  task automatic wait_ar_accept();
    #1;
    while (!o_arready) begin
      @(negedge clk);
      #1;
    end
  endtask

  task automatic issue_random_read(input bit in_range);
    @(negedge clk);
    drive_random_read(in_range);
    wait_ar_accept();
  endtask

  task automatic stop_ar();
    @(negedge clk);
    i_arvalid = 1'b0;
  endtask

  task automatic wait_drain();
    @(negedge clk);
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  // Writes cover the whole index space including the unbacked words
  task automatic preload_memory();
    for (int i = 0; i < INDEX_SPAN; i++) begin
      @(negedge clk);
      i_wr_en   = 1'b1;
      i_wr_addr = INDEX_W'(i);
      i_wr_data = next_rand();
      if (i < MEM_WORDS) begin
        mirror[i] = i_wr_data;
      end
    end
    @(negedge clk);
    i_wr_en = 1'b0;
  endtask

  task automatic test_reset_and_single();
    #1;
    if (o_rvalid !== 1'b0) begin
      report_mismatch("o_rvalid", 64'(0), 64'(o_rvalid));
    end
    if (o_arready !== 1'b1) begin
      report_mismatch("o_arready", 64'(1), 64'(o_arready));
    end
    preload_memory();
    @(negedge clk);
    i_rready = 1'b1;
    @(negedge clk);
    drive_ar(4'h9, word_addr(5));
    wait_ar_accept();
    stop_ar();
    wait_drain();
  endtask

  task automatic test_back_to_back();
    for (int i = 0; i < 20; i++) begin
      issue_random_read(1'b1);
    end
    stop_ar();
    wait_drain();
  endtask

  // Even reads in range and odd reads past the memory depth
  task automatic test_error_reads();
    for (int i = 0; i < 12; i++) begin
      issue_random_read(i % 2 == 0);
    end
    stop_ar();
    wait_drain();
  endtask

  task automatic test_backpressure();
    int accepted;
    bit took;
    accepted = 0;
    @(negedge clk);
    i_rready = 1'b0;
    drive_random_read(1'b1);
    for (int n = 0; n < 12; n++) begin
      #1;
      took = o_arready;
      @(negedge clk);
      if (took) begin
        accepted++;
        drive_random_read(1'b1);
      end
    end
    #1;
    if (accepted != 3) begin
      report_mismatch("accepted reads", 64'(3), 64'(accepted));
    end
    if (o_arready !== 1'b0) begin
      report_mismatch("o_arready", 64'(0), 64'(o_arready));
    end
    if (o_rvalid !== 1'b1) begin
      report_mismatch("o_rvalid", 64'(1), 64'(o_rvalid));
    end
  endtask

  // The fourth address is still pending from the back-pressure test
  task automatic test_random_drain();
    logic [31:0] r;
    bit          fourth_taken;
    fourth_taken = 1'b0;
    while (!fourth_taken) begin
      @(negedge clk);
      r = next_rand();
      i_rready = r[0];
      #1;
      fourth_taken = o_arready;
    end
    @(negedge clk);
    i_arvalid = 1'b0;
    while (exp_q.size() != 0) begin
      r = next_rand();
      i_rready = r[0];
      @(negedge clk);
    end
    i_rready = 1'b1;
    // Bus is idle again once the last beat has gone
    #1;
    if (o_rvalid !== 1'b0) begin
      report_mismatch("o_rvalid", 64'(0), 64'(o_rvalid));
    end
    if (o_arready !== 1'b1) begin
      report_mismatch("o_arready", 64'(1), 64'(o_arready));
    end
  endtask

  initial begin
    clk       = 1'b0;
    i_rst_n   = 1'b0;
    i_arvalid = 1'b0;
    i_arid    = '0;
    i_araddr  = '0;
    i_arlen   = '0;
    i_arsize  = 3'd2;
    i_arburst = 2'd1;
    i_rready  = 1'b0;
    i_wr_en   = 1'b0;
    i_wr_addr = '0;
    i_wr_data = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    i_rst_n = 1'b1;

    test_reset_and_single();
    test_back_to_back();
    test_error_reads();
    test_backpressure();
    test_random_drain();

    $display("errors: %0d, reads accepted: %0d, beats checked: %0d",
             errors, ar_count, beat_count);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* rtl/axi_rd_mem_top.sv */
module axi_rd_mem_top #(
  parameter int ADDR_WIDTH              = 8,
  parameter int DATA_WIDTH              = 32,
  parameter int ID_WIDTH                = 4,
  parameter int OUTSTANDING_READS_WIDTH = 2,
  parameter int MEM_WORDS               = 48
) (
  input  logic                                       clk,
  input  logic                                       i_rst_n,

  // AXI read address channel
  input  logic                                       i_arvalid,
  input  logic [ID_WIDTH-1:0]                        i_arid,
  input  logic [ADDR_WIDTH-1:0]                      i_araddr,
  input  logic [axi_rd_pkg::AXI_LEN_W-1:0]           i_arlen,
  input  logic [axi_rd_pkg::AXI_SIZE_W-1:0]          i_arsize,
  input  logic [axi_rd_pkg::AXI_BURST_W-1:0]         i_arburst,
  output logic                                       o_arready,

  // AXI read data channel
  output logic                                       o_rvalid,
  output logic [ID_WIDTH-1:0]                        o_rid,
  output logic [DATA_WIDTH-1:0]                      o_rdata,
  output logic [axi_rd_pkg::AXI_RESP_W-1:0]          o_rresp,
  output logic                                       o_rlast,
  input  logic                                       i_rready,

  // Memory preload
  input  logic                                       i_wr_en,
  input  logic [ADDR_WIDTH-$clog2(DATA_WIDTH/8)-1:0] i_wr_addr,
  input  logic [DATA_WIDTH-1:0]                      i_wr_data
);

  logic                                       axil_arvalid;
  logic [ADDR_WIDTH-1:0]                      axil_araddr;
  logic                                       axil_arready;
  logic                                       axil_rvalid;
  logic [DATA_WIDTH-1:0]                      axil_rdata;
  logic [axi_rd_pkg::AXI_RESP_W-1:0]          axil_rresp;
  logic                                       axil_rready;
  logic                                       lat_load;
  logic [axi_rd_pkg::LAT_W-1:0]               lat_value;
  logic                                       lat_done;
  logic [ADDR_WIDTH-$clog2(DATA_WIDTH/8)-1:0] mem_index;
  logic [DATA_WIDTH-1:0]                      mem_data;
  logic                                       mem_err;

  axi_axil_reflect_rd #(
    .ADDR_WIDTH             (ADDR_WIDTH),
    .DATA_WIDTH             (DATA_WIDTH),
    .ID_WIDTH               (ID_WIDTH),
    .OUTSTANDING_READS_WIDTH(OUTSTANDING_READS_WIDTH)
  ) u_bridge (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_arvalid     (i_arvalid),
    .i_arid        (i_arid),
    .i_araddr      (i_araddr),
    .i_arlen       (i_arlen),
    .i_arsize      (i_arsize),
    .i_arburst     (i_arburst),
    .o_arready     (o_arready),
    .o_rvalid      (o_rvalid),
    .o_rid         (o_rid),
    .o_rdata       (o_rdata),
    .o_rresp       (o_rresp),
    .o_rlast       (o_rlast),
    .i_rready      (i_rready),
    .o_axil_arvalid(axil_arvalid),
    .o_axil_araddr (axil_araddr),
    .i_axil_arready(axil_arready),
    .i_axil_rvalid (axil_rvalid),
    .i_axil_rdata  (axil_rdata),
    .i_axil_rresp  (axil_rresp),
    .o_axil_rready (axil_rready)
  );

  axil_rd_ctrl #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH)
  ) u_ctrl (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_arvalid  (axil_arvalid),
    .i_araddr   (axil_araddr),
    .o_arready  (axil_arready),
    .o_rvalid   (axil_rvalid),
    .o_rdata    (axil_rdata),
    .o_rresp    (axil_rresp),
    .i_rready   (axil_rready),
    .o_lat_load (lat_load),
    .o_lat_value(lat_value),
    .i_lat_done (lat_done),
    .o_mem_index(mem_index),
    .i_mem_data (mem_data),
    .i_mem_err  (mem_err)
  );

  rd_latency_timer u_timer (
    .clk    (clk),
    .i_rst_n(i_rst_n),
    .i_load (lat_load),
    .i_value(lat_value),
    .o_done (lat_done)
  );

  rd_mem #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH),
    .MEM_WORDS (MEM_WORDS)
  ) u_mem (
    .clk       (clk),
    .i_wr_en   (i_wr_en),
    .i_wr_addr (i_wr_addr),
    .i_wr_data (i_wr_data),
    .i_rd_index(mem_index),
    .o_rd_data (mem_data),
    .o_rd_err  (mem_err)
  );

endmodule

/* rtl/axi_axil_reflect_rd.sv */
module axi_axil_reflect_rd #(
  parameter int ADDR_WIDTH              = 8,
  parameter int DATA_WIDTH              = 32,
  parameter int ID_WIDTH                = 4,
  parameter int OUTSTANDING_READS_WIDTH = 2
) (
  input  logic                               clk,
  input  logic                               i_rst_n,

  // AXI subordinate read channels
  input  logic                               i_arvalid,
  input  logic [ID_WIDTH-1:0]                i_arid,
  input  logic [ADDR_WIDTH-1:0]              i_araddr,
  input  logic [axi_rd_pkg::AXI_LEN_W-1:0]   i_arlen,
  input  logic [axi_rd_pkg::AXI_SIZE_W-1:0]  i_arsize,
  input  logic [axi_rd_pkg::AXI_BURST_W-1:0] i_arburst,
  output logic                               o_arready,
  output logic                               o_rvalid,
  output logic [ID_WIDTH-1:0]                o_rid,
  output logic [DATA_WIDTH-1:0]              o_rdata,
  output logic [axi_rd_pkg::AXI_RESP_W-1:0]  o_rresp,
  output logic                               o_rlast,
  input  logic                               i_rready,

  // AXI-Lite manager read channels
  output logic                               o_axil_arvalid,
  output logic [ADDR_WIDTH-1:0]              o_axil_araddr,
  input  logic                               i_axil_arready,
  input  logic                               i_axil_rvalid,
  input  logic [DATA_WIDTH-1:0]              i_axil_rdata,
  input  logic [axi_rd_pkg::AXI_RESP_W-1:0]  i_axil_rresp,
  output logic                               o_axil_rready
);

  // Two queued addresses behind the one the controller is serving
  localparam int AR_FIFO_ADDR_WIDTH = 1;

  logic ar_fire;
  logic r_fire;
  logic ar_full;
  logic ar_empty;
  logic id_full;
  logic id_empty;

  assign ar_fire = i_arvalid && o_arready;
  assign r_fire  = o_rvalid && i_rready;

  sync_fifo_zl #(
    .ADDR_WIDTH(AR_FIFO_ADDR_WIDTH),
    .DATA_WIDTH(ADDR_WIDTH)
  ) u_ar_fifo (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .i_w_inc  (ar_fire),
    .i_w_data (i_araddr),
    .o_w_full (ar_full),
    .i_r_inc  (o_axil_arvalid && i_axil_arready),
    .o_r_data (o_axil_araddr),
    .o_r_empty(ar_empty)
  );

  // IDs wait here until their beat comes back from the controller
  sync_fifo_zl #(
    .ADDR_WIDTH(OUTSTANDING_READS_WIDTH),
    .DATA_WIDTH(ID_WIDTH)
  ) u_id_fifo (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .i_w_inc  (ar_fire),
    .i_w_data (i_arid),
    .o_w_full (id_full),
    .i_r_inc  (r_fire),
    .o_r_data (o_rid),
    .o_r_empty(id_empty)
  );

  assign o_arready      = !ar_full && !id_full;
  assign o_axil_arvalid = !ar_empty;

  // R beats pass through and are always the last beat
  assign o_rvalid      = i_axil_rvalid;
  assign o_rdata       = i_axil_rdata;
  assign o_rresp       = i_axil_rresp;
  assign o_rlast       = 1'b1;
  assign o_axil_rready = i_rready;

  // Only single-beat bursts are supported
  a_single_beat : assert property (
    @(posedge clk) disable iff (!i_rst_n)
    i_arvalid |-> (i_arlen == '0)
  );

  // Each returned beat must have a queued ID to reflect
  a_id_available : assert property (
    @(posedge clk) disable iff (!i_rst_n)
    i_axil_rvalid |-> !id_empty
  );

endmodule

/* rtl/axil_rd_ctrl.sv */
module axil_rd_ctrl #(
  parameter int ADDR_WIDTH = 8,
  parameter int DATA_WIDTH = 32
) (
  input  logic                                     clk,
  input  logic                                     i_rst_n,

  // AXI-Lite subordinate read channels
  input  logic                                     i_arvalid,
  input  logic [ADDR_WIDTH-1:0]                    i_araddr,
  output logic                                     o_arready,
  output logic                                     o_rvalid,
  output logic [DATA_WIDTH-1:0]                    o_rdata,
  output logic [axi_rd_pkg::AXI_RESP_W-1:0]        o_rresp,
  input  logic                                     i_rready,

  // Latency timer
  output logic                                     o_lat_load,
  output logic [axi_rd_pkg::LAT_W-1:0]             o_lat_value,
  input  logic                                     i_lat_done,

  // Memory read port
  output logic [ADDR_WIDTH-$clog2(DATA_WIDTH/8)-1:0] o_mem_index,
  input  logic [DATA_WIDTH-1:0]                    i_mem_data,
  input  logic                                     i_mem_err
);

  localparam int BYTE_W  = $clog2(DATA_WIDTH / 8);
  localparam int INDEX_W = ADDR_WIDTH - BYTE_W;

  localparam logic [axi_rd_pkg::LAT_W-1:0] LAT_BASE = {{(axi_rd_pkg::LAT_W-1){1'b0}}, 1'b1};

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_WAIT = 2'd1;
  localparam logic [1:0] S_RESP = 2'd2;

  logic [1:0]                        state;
  logic [INDEX_W-1:0]                index_q;
  logic [DATA_WIDTH-1:0]             rdata_q;
  logic [axi_rd_pkg::AXI_RESP_W-1:0] rresp_q;
  logic                              ar_fire;

  assign o_arready = (state == S_IDLE);
  assign ar_fire   = i_arvalid && o_arready;

  // Latency of 1 to 4 from the low two bits of the word index
  assign o_lat_load  = ar_fire;
  assign o_lat_value = {{(axi_rd_pkg::LAT_W-2){1'b0}}, i_araddr[BYTE_W +: 2]} + LAT_BASE;

  assign o_mem_index = index_q;

  assign o_rvalid = (state == S_RESP);
  assign o_rdata  = rdata_q;
  assign o_rresp  = rresp_q;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE: if (ar_fire) state <= S_WAIT;
        S_WAIT: if (i_lat_done) state <= S_RESP;
        S_RESP: if (i_rready) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      index_q <= i_araddr[ADDR_WIDTH-1:BYTE_W];
    end
    // Out of range reads return zero with SLVERR
    if (state == S_WAIT && i_lat_done) begin
      rdata_q <= i_mem_err ? '0 : i_mem_data;
      rresp_q <= i_mem_err ? axi_rd_pkg::RESP_SLVERR : axi_rd_pkg::RESP_OKAY;
    end
  end

  a_rvalid_hold : assert property (
    @(posedge clk) disable iff (!i_rst_n)
    o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata) && $stable(o_rresp)
  );

endmodule

/* rtl/rd_mem.sv */
module rd_mem #(
  parameter int ADDR_WIDTH = 8,
  parameter int DATA_WIDTH = 32,
  parameter int MEM_WORDS  = 48
) (
  input  logic                                       clk,

  // Preload port, word indexed
  input  logic                                       i_wr_en,
  input  logic [ADDR_WIDTH-$clog2(DATA_WIDTH/8)-1:0] i_wr_addr,
  input  logic [DATA_WIDTH-1:0]                      i_wr_data,

  // Asynchronous read
  input  logic [ADDR_WIDTH-$clog2(DATA_WIDTH/8)-1:0] i_rd_index,
  output logic [DATA_WIDTH-1:0]                      o_rd_data,
  output logic                                       o_rd_err
);

  logic [DATA_WIDTH-1:0] mem [MEM_WORDS];
  logic                  wr_in_range;

  // Index space is larger than the array, top words are unbacked
  assign wr_in_range = (int'(i_wr_addr) < MEM_WORDS);
  assign o_rd_err    = (int'(i_rd_index) >= MEM_WORDS);

  always_ff @(posedge clk) begin
    if (i_wr_en && wr_in_range) begin
      mem[i_wr_addr] <= i_wr_data;
    end
  end

  assign o_rd_data = o_rd_err ? '0 : mem[i_rd_index];

endmodule

/* rtl/rd_latency_timer.sv */
module rd_latency_timer (
  input  logic                         clk,
  input  logic                         i_rst_n,
  input  logic                         i_load,
  input  logic [axi_rd_pkg::LAT_W-1:0] i_value,
  output logic                         o_done
);

  localparam logic [axi_rd_pkg::LAT_W-1:0] CNT_ONE = {{(axi_rd_pkg::LAT_W-1){1'b0}}, 1'b1};

  logic [axi_rd_pkg::LAT_W-1:0] count;

  // Done is registered, so it rises i_value cycles after the load
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      count  <= '0;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (i_load) begin
        count <= i_value;
      end else if (count != '0) begin
        count  <= count - CNT_ONE;
        o_done <= (count == CNT_ONE);
      end
    end
  end

  // The controller only loads once the previous access has finished
  a_load_when_idle : assert property (
    @(posedge clk) disable iff (!i_rst_n)
    i_load |-> (count == '0) && (i_value != '0)
  );

endmodule

/* rtl/sync_fifo_zl.sv */
module sync_fifo_zl #(
  parameter int ADDR_WIDTH = 1,
  parameter int DATA_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  i_rst_n,

  input  logic                  i_w_inc,
  input  logic [DATA_WIDTH-1:0] i_w_data,
  output logic                  o_w_full,

  input  logic                  i_r_inc,
  output logic [DATA_WIDTH-1:0] o_r_data,
  output logic                  o_r_empty
);

  localparam int DEPTH = 1 << ADDR_WIDTH;
  localparam logic [ADDR_WIDTH:0] PTR_ONE = {{ADDR_WIDTH{1'b0}}, 1'b1};

  logic [DATA_WIDTH-1:0] mem [DEPTH];

  // Extra top bit tells full from empty when the indexes match
  logic [ADDR_WIDTH:0] w_ptr;
  logic [ADDR_WIDTH:0] r_ptr;
  logic                ptr_equal;

  assign ptr_equal = (w_ptr == r_ptr);

  assign o_w_full = (w_ptr[ADDR_WIDTH] != r_ptr[ADDR_WIDTH]) &&
                    (w_ptr[ADDR_WIDTH-1:0] == r_ptr[ADDR_WIDTH-1:0]);

  // Empty buffer hands the incoming word straight to the reader
  assign o_r_empty = ptr_equal && !i_w_inc;
  assign o_r_data  = ptr_equal ? i_w_data : mem[r_ptr[ADDR_WIDTH-1:0]];

  // A bypassed word is still written, and both pointers advance together
  always_ff @(posedge clk) begin
    if (i_w_inc) begin
      mem[w_ptr[ADDR_WIDTH-1:0]] <= i_w_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      w_ptr <= '0;
      r_ptr <= '0;
    end else begin
      if (i_w_inc) begin
        w_ptr <= w_ptr + PTR_ONE;
      end
      if (i_r_inc) begin
        r_ptr <= r_ptr + PTR_ONE;
      end
    end
  end

  // Callers must respect the flags
  a_no_overflow : assert property (
    @(posedge clk) disable iff (!i_rst_n)
    i_w_inc |-> !o_w_full
  );

  a_no_underflow : assert property (
    @(posedge clk) disable iff (!i_rst_n)
    i_r_inc |-> !o_r_empty
  );

endmodule

/* rtl/axi_rd_pkg.sv */
package axi_rd_pkg;

  // AXI read address channel field widths
  localparam int AXI_LEN_W = 8;
  localparam int AXI_SIZE_W = 3;
  localparam int AXI_BURST_W = 2;

  // Read response width and codes
  localparam int AXI_RESP_W = 2;

  localparam logic [AXI_RESP_W-1:0] RESP_OKAY = 2'b00;
  localparam logic [AXI_RESP_W-1:0] RESP_SLVERR = 2'b10;

  // Access latency counter width, enough for a load of 1 to 4
  localparam int LAT_W = 3;

endpackage
